//--- verilog/image_read_pkg.sv
package image_read_pkg;

    localparam int CFG_DWIDTH = 32;
    localparam int CFG_AWIDTH = 5;

    // configuration register map
    localparam logic [CFG_AWIDTH-1:0] CFG_IR_IMG_W  = 5'd0;
    localparam logic [CFG_AWIDTH-1:0] CFG_IR_IMG_DH = 5'd1;
    localparam logic [CFG_AWIDTH-1:0] CFG_IR_PAD    = 5'd2;
    localparam logic [CFG_AWIDTH-1:0] CFG_IR_CONV   = 5'd3;

    localparam int GROUP_NB    = 4;  // pixels per memory word
    localparam int PIX_WIDTH   = 16;
    localparam int BUS_WIDTH   = GROUP_NB * PIX_WIDTH;
    localparam int MEM_AWIDTH  = 16;
    localparam int COORD_WIDTH = 16;

    localparam int RD_LATENCY  = 3;  // read address to read data
    localparam int ADDR_PIPE   = 3;  // walker step to read address
    localparam int FIFO_AWIDTH = 4;  // 16 entry output buffer

    // one configuration word, decoded according to its address
    typedef union packed {
        logic [CFG_DWIDTH-1:0] raw;
        struct packed {
            logic [15:0] depth;
            logic [15:0] height;
        } dh;
        struct packed {
            logic [7:0] left;
            logic [7:0] right;
            logic [7:0] top;
            logic [7:0] bottom;
        } pad;
        struct packed {
            logic [7:0]  unused;  // was the maxpool side
            logic [7:0]  side;
            logic [15:0] step;
        } conv;
    } cfg_word_u;

endpackage

//--- verilog/geom_if.sv
`timescale 1ns/1ns

interface geom_if;
    import image_read_pkg::*;

    logic [COORD_WIDTH-1:0] img_d;
    logic [MEM_AWIDTH-1:0]  plane_wxd;   // addresses in one row of the image
    logic [COORD_WIDTH-1:0] pad_l;
    logic [COORD_WIDTH-1:0] pad_t;
    logic [COORD_WIDTH-1:0] edge_l;      // image edges in padded coordinates
    logic [COORD_WIDTH-1:0] edge_r;
    logic [COORD_WIDTH-1:0] edge_t;
    logic [COORD_WIDTH-1:0] edge_b;
    logic [COORD_WIDTH-1:0] conv_max;
    logic [COORD_WIDTH-1:0] conv_step;
    logic [COORD_WIDTH-1:0] area_w_max;  // last window launch positions
    logic [COORD_WIDTH-1:0] area_h_max;
    logic                   start;

    modport cfg_src (output img_d, plane_wxd, pad_l, pad_t, edge_l, edge_r, edge_t, edge_b,
                     conv_max, conv_step, area_w_max, area_h_max, start);
    modport walk_dst (input img_d, conv_max, conv_step, area_w_max, area_h_max, start);
    modport addr_dst (input img_d, plane_wxd, pad_l, pad_t, edge_l, edge_r, edge_t, edge_b);

endinterface

//--- verilog/walk_if.sv
`timescale 1ns/1ns

interface walk_if;
    import image_read_pkg::*;

    logic [COORD_WIDTH-1:0] x;  // padded column
    logic [COORD_WIDTH-1:0] y;  // padded row
    logic [COORD_WIDTH-1:0] d;
    logic                   step_val;
    logic                   step_last;

    modport src (output x, y, d, step_val, step_last);
    modport dst (input x, y, d, step_val, step_last);

endinterface

//--- verilog/image_read_cfg.sv
`timescale 1ns/1ns

module image_read_cfg (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [image_read_pkg::CFG_DWIDTH-1:0] cfg_data_i,
    input  logic [image_read_pkg::CFG_AWIDTH-1:0] cfg_addr_i,
    input  logic                                  cfg_valid_i,
    input  logic                                  next_i,
    input  logic                                  job_done_i,
    output logic                                  next_rdy_o,
    geom_if.cfg_src                               geom
);
    import image_read_pkg::*;

    cfg_word_u              cfg_w;
    cfg_word_u              cfg_dh;
    cfg_word_u              cfg_pad;
    cfg_word_u              cfg_conv;
    logic                   accept;
    logic                   busy;
    logic                   next_1p;
    logic                   next_2p;
    logic [COORD_WIDTH-1:0] img_w;
    logic [COORD_WIDTH-1:0] img_h;
    logic [COORD_WIDTH-1:0] img_d;
    logic [COORD_WIDTH-1:0] pad_l;
    logic [COORD_WIDTH-1:0] pad_r;
    logic [COORD_WIDTH-1:0] pad_t;
    logic [COORD_WIDTH-1:0] pad_b;
    logic [COORD_WIDTH-1:0] conv_side;
    logic [COORD_WIDTH-1:0] area_w;
    logic [COORD_WIDTH-1:0] area_h;
    logic [MEM_AWIDTH-1:0]  wxd;

    assign accept = next_i & next_rdy_o;

    always_ff @(posedge clk) begin
        if (cfg_valid_i) begin
            case (cfg_addr_i)
                CFG_IR_IMG_W:  cfg_w    <= cfg_data_i;
                CFG_IR_IMG_DH: cfg_dh   <= cfg_data_i;
                CFG_IR_PAD:    cfg_pad  <= cfg_data_i;
                CFG_IR_CONV:   cfg_conv <= cfg_data_i;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            next_rdy_o <= 1'b0;
        end else if (accept) begin
            busy       <= 1'b1;
            next_rdy_o <= 1'b0;
        end else begin
            if (job_done_i) busy <= 1'b0;
            next_rdy_o <= ~busy | job_done_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            next_1p    <= 1'b0;
            next_2p    <= 1'b0;
            geom.start <= 1'b0;
        end else begin
            next_1p    <= accept;
            next_2p    <= next_1p;
            geom.start <= next_2p;  // geometry has settled by now
        end
    end

    // stage 1: latch the words, zero based sizes become counts
    always_ff @(posedge clk) begin
        if (accept) begin
            img_w     <= cfg_w.raw[COORD_WIDTH-1:0] + 1'b1;
            img_h     <= cfg_dh.dh.height + 1'b1;
            img_d     <= cfg_dh.dh.depth + 1'b1;
            pad_l     <= COORD_WIDTH'(cfg_pad.pad.left);  // 0 is no padding
            pad_r     <= COORD_WIDTH'(cfg_pad.pad.right);
            pad_t     <= COORD_WIDTH'(cfg_pad.pad.top);
            pad_b     <= COORD_WIDTH'(cfg_pad.pad.bottom);
            conv_side <= COORD_WIDTH'(cfg_conv.conv.side) + 1'b1;
            geom.conv_step <= cfg_conv.conv.step + 1'b1;
        end
    end

    // stage 2: padded area and image edges
    always_ff @(posedge clk) begin
        area_w      <= pad_l + img_w + pad_r;
        area_h      <= pad_t + img_h + pad_b;
        geom.edge_l <= pad_l;
        geom.edge_t <= pad_t;
        geom.edge_r <= pad_l + img_w - 1'b1;
        geom.edge_b <= pad_t + img_h - 1'b1;
        wxd         <= MEM_AWIDTH'(img_w * img_d);
    end

    // stage 3: launch limits
    always_ff @(posedge clk) begin
        geom.area_w_max <= area_w - conv_side;
        geom.area_h_max <= area_h - conv_side;
        geom.conv_max   <= conv_side - 1'b1;
        geom.plane_wxd  <= wxd;
        geom.img_d      <= img_d;
        geom.pad_l      <= pad_l;
        geom.pad_t      <= pad_t;
    end

endmodule

//--- verilog/window_walker.sv
`timescale 1ns/1ns

module window_walker (
    input  logic      clk,
    input  logic      rst,
    geom_if.walk_dst  geom,
    input  logic      room_i,
    walk_if.src       walk,
    output logic      job_done_o
);
    import image_read_pkg::*;

    logic                   active;  // idle when low
    logic                   step;
    logic                   job_last;
    logic [COORD_WIDTH-1:0] d_cnt;
    logic [COORD_WIDTH-1:0] win_w_cnt;
    logic [COORD_WIDTH-1:0] win_h_cnt;
    logic [COORD_WIDTH-1:0] area_w_cnt;
    logic [COORD_WIDTH-1:0] area_h_cnt;
    logic [COORD_WIDTH:0]   area_w_nxt;
    logic [COORD_WIDTH:0]   area_h_nxt;
    logic                   d_last;
    logic                   win_w_last;
    logic                   win_h_last;
    logic                   area_w_last;
    logic                   area_h_last;

    assign step = active & room_i;  // freeze while the buffer is short of room

    assign area_w_nxt = {1'b0, area_w_cnt} + {1'b0, geom.conv_step};
    assign area_h_nxt = {1'b0, area_h_cnt} + {1'b0, geom.conv_step};

    assign d_last      = (d_cnt == geom.img_d - 1'b1);
    assign win_w_last  = (win_w_cnt == geom.conv_max);
    assign win_h_last  = (win_h_cnt == geom.conv_max);
    // one more step would leave too little area for a full window
    assign area_w_last = (area_w_nxt > {1'b0, geom.area_w_max});
    assign area_h_last = (area_h_nxt > {1'b0, geom.area_h_max});

    assign job_last = step & d_last & win_w_last & win_h_last & area_w_last & area_h_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (geom.start) begin
            active <= 1'b1;
        end else if (job_last) begin
            active <= 1'b0;
        end
    end

    // depth first, then window columns, rows, then window positions
    always_ff @(posedge clk) begin
        if (rst || !active) begin
            d_cnt      <= '0;
            win_w_cnt  <= '0;
            win_h_cnt  <= '0;
            area_w_cnt <= '0;
            area_h_cnt <= '0;
        end else if (step) begin
            d_cnt <= d_cnt + 1'b1;
            if (d_last) begin
                d_cnt     <= '0;
                win_w_cnt <= win_w_cnt + 1'b1;
                if (win_w_last) begin
                    win_w_cnt <= '0;
                    win_h_cnt <= win_h_cnt + 1'b1;
                    if (win_h_last) begin
                        win_h_cnt  <= '0;
                        area_w_cnt <= area_w_nxt[COORD_WIDTH-1:0];
                        if (area_w_last) begin
                            area_w_cnt <= '0;
                            area_h_cnt <= area_h_nxt[COORD_WIDTH-1:0];
                            if (area_h_last) area_h_cnt <= '0;
                        end
                    end
                end
            end
        end
    end

    assign walk.x         = area_w_cnt + win_w_cnt;
    assign walk.y         = area_h_cnt + win_h_cnt;
    assign walk.d         = d_cnt;
    assign walk.step_val  = step;
    assign walk.step_last = job_last;

    assign job_done_o = job_last;

endmodule

//--- verilog/addr_calc.sv
`timescale 1ns/1ns

module addr_calc (
    input  logic                                  clk,
    input  logic                                  rst,
    geom_if.addr_dst                              geom,
    walk_if.dst                                   walk,
    output logic                                  rd_val_o,
    output logic [image_read_pkg::MEM_AWIDTH-1:0] rd_addr_o,
    output logic                                  pad_val_o,
    output logic                                  last_o
);
    import image_read_pkg::*;

    logic                   outside;
    logic [COORD_WIDTH-1:0] x_1p;
    logic [COORD_WIDTH-1:0] y_1p;
    logic [COORD_WIDTH-1:0] d_1p;
    logic [COORD_WIDTH-1:0] d_2p;
    logic [MEM_AWIDTH-1:0]  row_2p;
    logic [MEM_AWIDTH-1:0]  col_2p;
    logic                   val_1p;
    logic                   val_2p;
    logic                   pad_1p;
    logic                   pad_2p;
    logic                   last_1p;
    logic                   last_2p;

    // pixel lies in the padding band around the image
    assign outside = (walk.x < geom.edge_l) | (walk.x > geom.edge_r)
                   | (walk.y < geom.edge_t) | (walk.y > geom.edge_b);

    always_ff @(posedge clk) begin
        if (rst) begin
            val_1p    <= 1'b0;
            pad_1p    <= 1'b0;
            last_1p   <= 1'b0;
            val_2p    <= 1'b0;
            pad_2p    <= 1'b0;
            last_2p   <= 1'b0;
            rd_val_o  <= 1'b0;
            pad_val_o <= 1'b0;
            last_o    <= 1'b0;
        end else begin
            val_1p    <= walk.step_val;
            pad_1p    <= walk.step_val & outside;
            last_1p   <= walk.step_last;
            val_2p    <= val_1p;
            pad_2p    <= pad_1p;
            last_2p   <= last_1p;
            rd_val_o  <= val_2p & ~pad_2p;  // padding never reaches memory
            pad_val_o <= pad_2p;
            last_o    <= last_2p;
        end
    end

    always_ff @(posedge clk) begin
        x_1p <= walk.x;
        y_1p <= walk.y;
        d_1p <= walk.d;

        // unpadded row and column offsets, garbage for padding pixels
        row_2p <= MEM_AWIDTH'((y_1p - geom.pad_t) * geom.plane_wxd);
        col_2p <= MEM_AWIDTH'((x_1p - geom.pad_l) * geom.img_d);
        d_2p   <= d_1p;

        rd_addr_o <= row_2p + col_2p + MEM_AWIDTH'(d_2p);
    end

endmodule

//--- verilog/image_stream_buf.sv
`timescale 1ns/1ns

module image_stream_buf (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 rd_val_i,
    input  logic                                 pad_val_i,
    input  logic                                 last_i,
    input  logic [image_read_pkg::BUS_WIDTH-1:0] rd_data_i,
    output logic                                 room_o,
    output logic [image_read_pkg::BUS_WIDTH-1:0] image_bus_o,
    output logic                                 image_last_o,
    output logic                                 image_val_o,
    input  logic                                 image_rdy_i
);
    import image_read_pkg::*;

    logic [RD_LATENCY-1:0]  val_sr;
    logic [RD_LATENCY-1:0]  pad_sr;
    logic [RD_LATENCY-1:0]  last_sr;
    logic                   push;
    logic                   push_last;
    logic [BUS_WIDTH-1:0]   push_data;
    logic [BUS_WIDTH:0]     mem [0:(1 << FIFO_AWIDTH)-1];  // word and last flag
    logic [FIFO_AWIDTH-1:0] wr_ptr;
    logic [FIFO_AWIDTH-1:0] rd_ptr;
    logic [FIFO_AWIDTH:0]   count;
    logic                   pop;

    // line the flags up with the data coming back from memory
    always_ff @(posedge clk) begin
        if (rst) begin
            val_sr  <= '0;
            pad_sr  <= '0;
            last_sr <= '0;
            push    <= 1'b0;
        end else begin
            val_sr  <= {val_sr[RD_LATENCY-2:0], rd_val_i};
            pad_sr  <= {pad_sr[RD_LATENCY-2:0], pad_val_i};
            last_sr <= {last_sr[RD_LATENCY-2:0], last_i};
            push    <= val_sr[RD_LATENCY-1] | pad_sr[RD_LATENCY-1];
        end
    end

    always_ff @(posedge clk) begin
        push_last <= last_sr[RD_LATENCY-1];
        push_data <= val_sr[RD_LATENCY-1] ? rd_data_i : '0;  // zero word for padding
    end

    // refill the output register when it is empty or being taken
    assign pop = (count != 0) & (~image_val_o | image_rdy_i);

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= {push_data, push_last};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + push - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            image_val_o <= 1'b0;
        end else if (pop) begin
            image_val_o <= 1'b1;
        end else if (image_rdy_i) begin
            image_val_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) {image_bus_o, image_last_o} <= mem[rd_ptr];  // held while stalled
    end

    // leave space for everything the address pipe and memory still hold
    assign room_o = ((1 << FIFO_AWIDTH) - count) > (ADDR_PIPE + RD_LATENCY + 2);

endmodule

//--- verilog/image_read.sv
`timescale 1ns/1ns

module image_read (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [image_read_pkg::CFG_DWIDTH-1:0] cfg_data_i,
    input  logic [image_read_pkg::CFG_AWIDTH-1:0] cfg_addr_i,
    input  logic                                  cfg_valid_i,
    input  logic                                  next_i,
    output logic                                  next_rdy_o,
    output logic                                  rd_val_o,
    output logic [image_read_pkg::MEM_AWIDTH-1:0] rd_addr_o,
    input  logic [image_read_pkg::BUS_WIDTH-1:0]  rd_data_i,
    output logic [image_read_pkg::BUS_WIDTH-1:0]  image_bus_o,
    output logic                                  image_last_o,
    output logic                                  image_val_o,
    input  logic                                  image_rdy_i
);

    geom_if geom ();
    walk_if walk ();

    logic job_done;
    logic room;
    logic pad_val;
    logic addr_last;

    image_read_cfg u_cfg (
        .clk         (clk),
        .rst         (rst),
        .cfg_data_i  (cfg_data_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_valid_i (cfg_valid_i),
        .next_i      (next_i),
        .job_done_i  (job_done),
        .next_rdy_o  (next_rdy_o),
        .geom        (geom.cfg_src)
    );

    window_walker u_walker (
        .clk        (clk),
        .rst        (rst),
        .geom       (geom.walk_dst),
        .room_i     (room),
        .walk       (walk.src),
        .job_done_o (job_done)
    );

    addr_calc u_addr (
        .clk       (clk),
        .rst       (rst),
        .geom      (geom.addr_dst),
        .walk      (walk.dst),
        .rd_val_o  (rd_val_o),
        .rd_addr_o (rd_addr_o),
        .pad_val_o (pad_val),
        .last_o    (addr_last)
    );

    image_stream_buf u_buf (
        .clk          (clk),
        .rst          (rst),
        .rd_val_i     (rd_val_o),
        .pad_val_i    (pad_val),
        .last_i       (addr_last),
        .rd_data_i    (rd_data_i),
        .room_o       (room),
        .image_bus_o  (image_bus_o),
        .image_last_o (image_last_o),
        .image_val_o  (image_val_o),
        .image_rdy_i  (image_rdy_i)
    );

endmodule

//--- sim/image_read_props.sv
`timescale 1ns/1ns

module image_read_props (
    input logic                                   clk,
    input logic                                   rst,
    input logic                                   next_i,
    input logic                                   next_rdy_o,
    input logic                                   rd_val_o,
    input logic                                   pad_val_i,
    input logic                                   step_val_i,
    input logic [image_read_pkg::COORD_WIDTH-1:0] walk_x_i,
    input logic [image_read_pkg::COORD_WIDTH-1:0] walk_y_i,
    input logic [image_read_pkg::COORD_WIDTH-1:0] edge_l_i,
    input logic [image_read_pkg::COORD_WIDTH-1:0] edge_r_i,
    input logic [image_read_pkg::COORD_WIDTH-1:0] edge_t_i,
    input logic [image_read_pkg::COORD_WIDTH-1:0] edge_b_i,
    input logic [image_read_pkg::BUS_WIDTH-1:0]   image_bus_o,
    input logic                                   image_last_o,
    input logic                                   image_val_o,
    input logic                                   image_rdy_i
);
    import image_read_pkg::*;

    logic in_image;

    // walker position lies inside the unpadded image
    assign in_image = (walk_x_i >= edge_l_i) && (walk_x_i <= edge_r_i)
                   && (walk_y_i >= edge_t_i) && (walk_y_i <= edge_b_i);

    // a stalled word keeps its data and flag
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        image_val_o && !image_rdy_i |=> $stable(image_bus_o) && $stable(image_last_o))
        else $error("output word changed while stalled");

    val_keep: assert property (@(posedge clk) disable iff (rst)
        image_val_o && !image_rdy_i |=> image_val_o)
        else $error("image_val_o fell without a transfer");

    next_gate: assert property (@(posedge clk) disable iff (rst) next_i |-> next_rdy_o)
        else $error("next_i raised while next_rdy_o was low");

    pad_no_read: assert property (@(posedge clk) disable iff (rst)
        step_val_i && !in_image |-> ##ADDR_PIPE pad_val_i && !rd_val_o)
        else $error("memory read issued for a padding pixel");

endmodule

bind image_read image_read_props u_props (
    .clk          (clk),
    .rst          (rst),
    .next_i       (next_i),
    .next_rdy_o   (next_rdy_o),
    .rd_val_o     (rd_val_o),
    .pad_val_i    (pad_val),
    .step_val_i   (walk.step_val),
    .walk_x_i     (walk.x),
    .walk_y_i     (walk.y),
    .edge_l_i     (geom.edge_l),
    .edge_r_i     (geom.edge_r),
    .edge_t_i     (geom.edge_t),
    .edge_b_i     (geom.edge_b),
    .image_bus_o  (image_bus_o),
    .image_last_o (image_last_o),
    .image_val_o  (image_val_o),
    .image_rdy_i  (image_rdy_i)
);

//--- sim/tb_image_read.sv
`timescale 1ns/1ns

module tb_image_read;
    import image_read_pkg::*;

    typedef struct packed {
        int w;
        int h;
        int d;
        int pl;
        int pr;
        int pt;
        int pb;
        int side;
        int step;
    } job_t;

    logic                  clk;
    logic                  rst;
    logic [CFG_DWIDTH-1:0] cfg_data_i;
    logic [CFG_AWIDTH-1:0] cfg_addr_i;
    logic                  cfg_valid_i;
    logic                  next_i;
    logic                  next_rdy_o;
    logic                  rd_val_o;
    logic [MEM_AWIDTH-1:0] rd_addr_o;
    logic [BUS_WIDTH-1:0]  rd_data_i;
    logic [BUS_WIDTH-1:0]  image_bus_o;
    logic                  image_last_o;
    logic                  image_val_o;
    logic                  image_rdy_i;

    logic [BUS_WIDTH:0]    exp_q [$];  // word and last flag, in stream order
    logic [MEM_AWIDTH-1:0] addr_pipe [RD_LATENCY];
    integer                seed;
    int                    rx_count;
    int                    rx_lasts;
    int                    total;
    bit                    rdy_random;
    int                    stretch;
    logic                  rdy_level;
    job_t                  job;
    job_t                  jobs [6];

    image_read DUT (
        .clk          (clk),
        .rst          (rst),
        .cfg_data_i   (cfg_data_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_valid_i  (cfg_valid_i),
        .next_i       (next_i),
        .next_rdy_o   (next_rdy_o),
        .rd_val_o     (rd_val_o),
        .rd_addr_o    (rd_addr_o),
        .rd_data_i    (rd_data_i),
        .image_bus_o  (image_bus_o),
        .image_last_o (image_last_o),
        .image_val_o  (image_val_o),
        .image_rdy_i  (image_rdy_i)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [BUS_WIDTH:0] got, input logic [BUS_WIDTH:0] exp,
                               input string what);
        if (got !== exp)
            fail_run($sformatf("Mismatch at %0t ns: %s, got %h, expected %h",
                               $time, what, got, exp));
    endtask

    // every pixel of a memory word is its address plus the lane
    function automatic logic [BUS_WIDTH-1:0] mem_word(input logic [MEM_AWIDTH-1:0] addr);
        logic [BUS_WIDTH-1:0] w;
        int k;
        for (k = 0; k < GROUP_NB; k++)
            w[k*PIX_WIDTH +: PIX_WIDTH] = PIX_WIDTH'(addr) + PIX_WIDTH'(k);
        return w;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic int word_count(input job_t j);
        int pos_w;
        int pos_h;
        pos_w = (j.pl + j.w + j.pr - j.side) / j.step + 1;
        pos_h = (j.pt + j.h + j.pb - j.side) / j.step + 1;
        return pos_w * pos_h * j.side * j.side * j.d;
    endfunction

    // window positions row by row, inside a window depth first, then columns, then rows
    function automatic void build_expected(input job_t j);
        int ah;
        int aw;
        int wr;
        int wc;
        int dd;
        int x;
        int y;
        logic [BUS_WIDTH-1:0] word;
        logic [BUS_WIDTH:0]   tail;
        for (ah = 0; ah + j.side <= j.pt + j.h + j.pb; ah += j.step)
            for (aw = 0; aw + j.side <= j.pl + j.w + j.pr; aw += j.step)
                for (wr = 0; wr < j.side; wr++)
                    for (wc = 0; wc < j.side; wc++)
                        for (dd = 0; dd < j.d; dd++) begin
                            x = aw + wc;
                            y = ah + wr;
                            if (x >= j.pl && x < j.pl + j.w && y >= j.pt && y < j.pt + j.h)
                                word = mem_word(MEM_AWIDTH'((y - j.pt) * j.w * j.d
                                                            + (x - j.pl) * j.d + dd));
                            else
                                word = '0;  // padding pixel
                            exp_q.push_back({word, 1'b0});
                        end
        tail = exp_q.pop_back();
        exp_q.push_back(tail | 1'b1);
    endfunction

    function automatic job_t random_job();
        job_t j;
        int lim;
        j.w  = rand_range(1, 6);
        j.h  = rand_range(1, 6);
        j.d  = rand_range(1, 4);
        j.pl = rand_range(0, 2);
        j.pr = rand_range(0, 2);
        j.pt = rand_range(0, 2);
        j.pb = rand_range(0, 2);
        lim = 3;
        if (j.pl + j.w + j.pr < lim) lim = j.pl + j.w + j.pr;
        if (j.pt + j.h + j.pb < lim) lim = j.pt + j.h + j.pb;
        j.side = rand_range(1, lim);
        j.step = rand_range(1, 3);
        return j;
    endfunction

    task automatic write_cfg(input logic [CFG_AWIDTH-1:0] addr, input logic [CFG_DWIDTH-1:0] data);
        cfg_addr_i  = addr;
        cfg_data_i  = data;
        cfg_valid_i = 1'b1;
        @(negedge clk);
        cfg_valid_i = 1'b0;
    endtask

    task automatic wait_next_rdy();
        int cycles;
        cycles = 0;
        while (!next_rdy_o && cycles < 20000) begin
            @(negedge clk);
            cycles++;
        end
        if (!next_rdy_o) fail_run("next_rdy_o never came back high");
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 20000) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) fail_run("output stream stopped before all expected words arrived");
    endtask

    task automatic run_job(input job_t j);
        cfg_word_u word;
        word.raw = '0;
        word.raw[COORD_WIDTH-1:0] = COORD_WIDTH'(j.w - 1);
        write_cfg(CFG_IR_IMG_W, word.raw);
        word.dh.depth  = 16'(j.d - 1);
        word.dh.height = 16'(j.h - 1);
        write_cfg(CFG_IR_IMG_DH, word.raw);
        word.pad.left   = 8'(j.pl);
        word.pad.right  = 8'(j.pr);
        word.pad.top    = 8'(j.pt);
        word.pad.bottom = 8'(j.pb);
        write_cfg(CFG_IR_PAD, word.raw);
        word.conv.unused = 8'h5a;  // must be ignored
        word.conv.side   = 8'(j.side - 1);
        word.conv.step   = 16'(j.step - 1);
        write_cfg(CFG_IR_CONV, word.raw);
        wait_next_rdy();
        build_expected(j);
        next_i = 1'b1;
        @(negedge clk);
        next_i = 1'b0;
        check_equal(next_rdy_o, 1'b0, "next_rdy_o after a job started");
    endtask

    // memory answers RD_LATENCY cycles after the address
    always @(posedge clk) begin
        addr_pipe[0] <= rd_addr_o;
        for (int k = 1; k < RD_LATENCY; k++) addr_pipe[k] <= addr_pipe[k-1];
    end

    always @(negedge clk) rd_data_i <= mem_word(addr_pipe[RD_LATENCY-1]);

    // ready alternates between random stretches of low and high
    always @(negedge clk) begin
        if (!rdy_random) begin
            image_rdy_i <= 1'b1;
        end else begin
            if (stretch == 0) begin
                stretch   = rand_range(1, 24);
                rdy_level = ~rdy_level;
            end
            stretch = stretch - 1;
            image_rdy_i <= rdy_level;
        end
    end

    always @(posedge clk) begin
        if (!rst && image_val_o && image_rdy_i) begin
            if (exp_q.size() == 0) begin
                fail_run("an output word arrived that no job expected");
            end else begin
                check_equal({image_bus_o, image_last_o}, exp_q.pop_front(),
                            $sformatf("output word %0d", rx_count));
                rx_count++;
                if (image_last_o) rx_lasts++;
            end
        end
    end

    initial begin
        seed        = 32'h64fc;
        clk         = 1'b0;
        rst         = 1'b1;
        cfg_data_i  = '0;
        cfg_addr_i  = '0;
        cfg_valid_i = 1'b0;
        next_i      = 1'b0;
        rd_data_i   = '0;
        image_rdy_i = 1'b1;
        rdy_random  = 1'b0;
        stretch     = 0;
        rdy_level   = 1'b1;
        rx_count    = 0;
        rx_lasts    = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // quiet outputs after reset
        check_equal(next_rdy_o, 1'b0, "next_rdy_o right after reset");
        @(negedge clk);
        check_equal(next_rdy_o, 1'b1, "next_rdy_o one cycle after reset");
        repeat (4) begin
            check_equal(rd_val_o, 1'b0, "rd_val_o while idle");
            check_equal(image_val_o, 1'b0, "image_val_o while idle");
            @(negedge clk);
        end

        // plain 1x1 walk reads the image in memory order
        job = '{w: 4, h: 3, d: 2, pl: 0, pr: 0, pt: 0, pb: 0, side: 1, step: 1};
        rx_count = 0;
        run_job(job);
        drain();
        check_equal(rx_count, 4 * 3 * 2, "word count of the 1x1 job");
        wait_next_rdy();

        job = '{w: 3, h: 3, d: 2, pl: 1, pr: 2, pt: 1, pb: 2, side: 3, step: 1};
        rx_count = 0;
        run_job(job);
        drain();
        check_equal(rx_count, word_count(job), "word count of the padded job");
        wait_next_rdy();

        job = '{w: 7, h: 6, d: 3, pl: 0, pr: 0, pt: 0, pb: 0, side: 3, step: 2};
        rx_count = 0;
        run_job(job);
        drain();
        check_equal(rx_count, word_count(job), "word count of the 3x3 job");
        wait_next_rdy();

        // draw all configurations first, then run them back to back
        total = 0;
        foreach (jobs[i]) begin
            jobs[i] = random_job();
            total += word_count(jobs[i]);
        end

        // same job under heavy back-pressure
        rdy_random = 1'b1;
        rx_count = 0;
        run_job(job);
        drain();
        check_equal(rx_count, word_count(job), "word count under back-pressure");
        wait_next_rdy();

        rx_count = 0;
        rx_lasts = 0;
        foreach (jobs[i]) run_job(jobs[i]);
        drain();
        check_equal(rx_count, total, "word count of the back-to-back jobs");
        check_equal(rx_lasts, 6, "last flags of the back-to-back jobs");
        rdy_random = 1'b0;
        wait_next_rdy();

        // nothing more may come out once every job is done
        repeat (16) begin
            check_equal(image_val_o, 1'b0, "image_val_o after the last job");
            check_equal(rd_val_o, 1'b0, "rd_val_o after the last job");
            @(negedge clk);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

//--- flist.f
verilog/image_read_pkg.sv
verilog/geom_if.sv
verilog/walk_if.sv
verilog/image_read_cfg.sv
verilog/window_walker.sv
verilog/addr_calc.sv
verilog/image_stream_buf.sv
verilog/image_read.sv
sim/image_read_props.sv
sim/tb_image_read.sv
